// ==== dv/mdll_dcdl_stim.txt ====
# columns: delay code (hex), expected output phase (hex)
# code = coarse << 4 | fine, phase = coarse * 64 + fine * 4
00 0000
0f 003c
01 0004
08 0020
0a 0028
10 0040
1f 007c
23 008c
2e 00b8
37 00dc
3b 00ec
45 0114
4a 0128
54 0150
5c 0170
60 0180
66 0198
69 01a4
70 01c0
71 01c4
7e 01f8
7f 01fc

// ==== dv/mdll_dcdl_tb.sv ====
// dcdl subsystem testbench
`timescale 1ns/10ps

module mdll_dcdl_tb;

	localparam int N_RAND   = 16;
	localparam int ACK_WAIT = 4;
	// cycle budget per test for the timeout
	localparam int TEST_LEN = 40;

	logic                clk = 1'b0;
	logic                rst_n;
	mdll_pkg::wb_req_t   wb_req;
	mdll_pkg::wb_rsp_t   wb_rsp;
	mdll_pkg::thm_t      ctl_thm;
	mdll_pkg::phase_t    phase_out;

	// directed codes and their expected phases
	logic [7:0]          stim_code[$];
	logic [15:0]         stim_phase[$];
	int                  errors = 0;
	int                  checks = 0;
	int                  tests_run = 0;
	int                  tests_failed = 0;
	int                  cycle_cnt = 0;
	int                  cycle_limit = 8 * TEST_LEN;

	mdll_dcdl_top uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.ctl_thm   (ctl_thm),
		.phase_out (phase_out)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// ----------------------------------------------------------
	// timeout
	// ----------------------------------------------------------

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("simulation timed out after %0d cycles", cycle_cnt);
			$display("Testbench failed");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// reference model and helpers
	// ----------------------------------------------------------

	// coarse * 64 + (64 * fine) >> 4, code masked to 7 bits
	function automatic logic [15:0] phase_rule(input logic [7:0] c);
		return 16'(c[6:4]) * 16'd64 + ((16'd64 * 16'(c[3:0])) >> 4);
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] count_ones(input mdll_pkg::thm_t w);
		logic [31:0] n;
		n = '0;
		for (int i = 0; i < 16; i++)
			n = n + {31'h0, w[i]};
		return n;
	endfunction

	task automatic check_eq(input string sig, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("error %s got 0x%h expected 0x%h", sig, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int nerr);
		tests_run++;
		if (nerr == 0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, nerr);
		end
	endtask

	// ----------------------------------------------------------
	// wishbone master
	// ----------------------------------------------------------

	// request on a rising edge, held until ack, ends on a falling edge
	task automatic bus_cycle(input logic we, input mdll_pkg::wb_addr_t adr,
			input mdll_pkg::wb_data_t wdat, output mdll_pkg::wb_data_t rdat);
		int waited;
		waited = 0;
		@(posedge clk);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we  <= we;
		wb_req.adr <= adr;
		wb_req.dat <= wdat;
		@(negedge clk);
		while (!wb_rsp.ack && waited < ACK_WAIT) begin
			waited++;
			@(negedge clk);
		end
		assert (wb_rsp.ack) else begin
			$display("bus cycle to address 0x%h was never acked", adr);
			errors++;
		end
		// read data valid in the ack cycle
		rdat = wb_rsp.dat;
		@(posedge clk);
		wb_req.cyc <= 1'b0;
		wb_req.stb <= 1'b0;
		wb_req.we  <= 1'b0;
		@(negedge clk);
	endtask

	task automatic bus_write(input mdll_pkg::wb_addr_t adr, input mdll_pkg::wb_data_t dat);
		mdll_pkg::wb_data_t unused_rd;
		bus_cycle(1'b1, adr, dat, unused_rd);
	endtask

	task automatic bus_read(input mdll_pkg::wb_addr_t adr, output mdll_pkg::wb_data_t dat);
		bus_cycle(1'b0, adr, 32'h0, dat);
	endtask

	// poll busy, the timeout bounds this loop
	task automatic wait_idle();
		mdll_pkg::wb_data_t st;
		st = 32'h1;
		while (st[0])
			bus_read(mdll_pkg::REG_STATUS, st);
	endtask

	// one code and expected phase per line, # lines skipped
	task automatic load_stim();
		int          fd;
		string       line;
		logic [7:0]  c;
		logic [15:0] p;
		fd = $fopen("dv/mdll_dcdl_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open stimulus file dv/mdll_dcdl_stim.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() > 2 && line.getc(0) != "#" && $sscanf(line, "%h %h", c, p) == 2) begin
				stim_code.push_back(c);
				stim_phase.push_back(p);
			end
		end
		$fclose(fd);
		if (stim_code.size() == 0) begin
			$display("stimulus file holds no directed codes");
			errors++;
		end
	endtask

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------

	initial begin
		mdll_pkg::wb_data_t rd;
		logic [31:0]        rnd;
		logic [7:0]         c;
		int                 start;
		int                 pre;
		int                 thm_errs;
		rst_n  <= 1'b0;
		wb_req <= '0;
		load_stim();
		cycle_limit = (stim_code.size() + N_RAND + 6) * TEST_LEN;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// registers and thermometer clear after reset
		start = errors;
		bus_read(mdll_pkg::REG_STATUS, rd);
		check_eq("STATUS", rd, 32'h0);
		bus_read(mdll_pkg::REG_PHASE, rd);
		check_eq("PHASE", rd, 32'h0);
		bus_read(mdll_pkg::REG_CODE, rd);
		check_eq("CODE", rd, 32'h0);
		check_eq("ctl_thm", {16'h0, ctl_thm}, 32'h0);
		report_test("reset state", errors - start);

		// only 7 code bits are kept
		start = errors;
		bus_write(mdll_pkg::REG_CODE, 32'hff);
		bus_read(mdll_pkg::REG_CODE, rd);
		check_eq("CODE", rd, 32'h7f);
		bus_read(4'd5, rd);
		check_eq("unmapped read", rd, 32'h0);
		wait_idle();
		report_test("code masking", errors - start);

		// directed codes, thermometer checked alongside
		start = errors;
		thm_errs = 0;
		foreach (stim_code[i]) begin
			bus_write(mdll_pkg::REG_CODE, {24'h0, stim_code[i]});
			wait_idle();
			bus_read(mdll_pkg::REG_PHASE, rd);
			check_eq("PHASE", rd, {16'h0, stim_phase[i]});
			check_eq("phase_out", {16'h0, phase_out}, {16'h0, stim_phase[i]});
			pre = errors;
			check_eq("ctl_thm ones", count_ones(ctl_thm), {28'h0, stim_code[i][3:0]});
			// contiguous ones from bit 0
			check_eq("ctl_thm", {16'h0, ctl_thm}, (32'h1 << stim_code[i][3:0]) - 32'h1);
			thm_errs += errors - pre;
		end
		report_test("directed blending", errors - start - thm_errs);
		report_test("thermometer output", thm_errs);

		// second write lands while the first is in the pipeline
		start = errors;
		bus_write(mdll_pkg::REG_CODE, 32'h25);
		bus_write(mdll_pkg::REG_CODE, 32'h6b);
		bus_read(mdll_pkg::REG_STATUS, rd);
		check_eq("STATUS busy", {31'h0, rd[0]}, 32'h1);
		wait_idle();
		bus_read(mdll_pkg::REG_PHASE, rd);
		check_eq("PHASE", rd, {16'h0, phase_rule(8'h6b)});
		report_test("overlapping updates", errors - start);

		// full 8 bit codes, masking applies
		start = errors;
		rnd = 32'haf3ea98e;
		repeat (N_RAND) begin
			rnd = xorshift(rnd);
			c = rnd[7:0];
			bus_write(mdll_pkg::REG_CODE, {24'h0, c});
			wait_idle();
			bus_read(mdll_pkg::REG_PHASE, rd);
			check_eq("PHASE", rd, {16'h0, phase_rule(c & 8'h7f)});
		end
		report_test("random codes", errors - start);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== hw/mdll_dcdl_coarse_chain.sv ====
// dcdl coarse delay chain
`timescale 1ns/10ps

module mdll_dcdl_coarse_chain #(
	parameter int STAGE_DELAY = 64
) (
	input  mdll_pkg::code_t    coarse_sel,
	output mdll_pkg::phase_t   phase_lead,
	output mdll_pkg::phase_t   phase_lag
);

	// one stage of the chain in phase units
	localparam mdll_pkg::phase_t STEP = mdll_pkg::phase_t'(STAGE_DELAY);

	int tap_idx;

	// ----------------------------------------------------------
	// tap selection
	// ----------------------------------------------------------

	// lead tap index is the coarse select
	assign tap_idx = int'(coarse_sel);

	// lead tap output after tap_idx stages
	assign phase_lead = mdll_pkg::phase_t'(tap_idx * STAGE_DELAY);

	// lag tap is the next stage along
	// so lead always leads lag by one stage
	assign phase_lag = phase_lead + STEP;

endmodule

// ==== hw/mdll_dcdl_code_decoder.sv ====
// dcdl delay code decoder
`timescale 1ns/10ps

module mdll_dcdl_code_decoder #(
	parameter int N_PI     = 4,
	parameter int N_COARSE = 3
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              upd_valid,
	input  mdll_pkg::code_t   code,
	output logic              dec_valid,
	output mdll_pkg::code_t   coarse_sel,
	output mdll_pkg::thm_t    ctl_thm
);

	// blender has 2**N_PI-1 mux legs
	localparam int N_THM = 2**N_PI - 1;

	logic [N_PI-1:0]      fine;
	logic [N_COARSE-1:0]  coarse;
	mdll_pkg::thm_t       thm_d;

	// upper field picks the tap pair, lower field the blend
	assign fine   = code[N_PI-1:0];
	assign coarse = code[N_PI +: N_COARSE];

	// binary to thermometer
	// ones packed from bit 0, count equals fine
	always_comb begin
		thm_d = '0;
		for (int i = 0; i < N_THM; i++) begin
			thm_d[i] = (int'(fine) > i);
		end
	end

	// ----------------------------------------------------------
	// decode stage register
	// ----------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid  <= 1'b0;
			coarse_sel <= '0;
			ctl_thm    <= '0;
		end else begin
			dec_valid <= upd_valid;
			// hold last code between updates
			if (upd_valid) begin
				coarse_sel <= mdll_pkg::code_t'(coarse);
				ctl_thm    <= thm_d;
			end
		end
	end

endmodule

// ==== hw/mdll_dcdl_ctrl.sv ====
// dcdl bus control and update sequencer
`timescale 1ns/10ps

module mdll_dcdl_ctrl #(
	parameter int N_PI     = 4,
	parameter int N_COARSE = 3
) (
	input  logic                clk,
	input  logic                rst_n,
	input  mdll_pkg::wb_req_t   wb_req,
	output mdll_pkg::wb_rsp_t   wb_rsp,
	output logic                upd_valid,
	output mdll_pkg::code_t     code,
	input  logic                phase_valid,
	input  mdll_pkg::phase_t    phase_out
);

	localparam int CODE_W = N_COARSE + N_PI;
	// only coarse and fine bits are stored
	localparam mdll_pkg::code_t CODE_MASK = mdll_pkg::code_t'((1 << CODE_W) - 1);

	logic                   ack_q;
	mdll_pkg::wb_data_t     rdat_q;
	mdll_pkg::wb_data_t     rd_data;
	mdll_pkg::phase_t       phase_q;
	mdll_pkg::upd_state_t   state_q;
	mdll_pkg::upd_state_t   state_d;
	logic [1:0]             inflight_q;
	logic                   bus_req;
	logic                   code_wr;
	logic                   busy;

	// ----------------------------------------------------------
	// bus decode
	// ----------------------------------------------------------

	// new request, ack low means not yet served
	assign bus_req = wb_req.cyc & wb_req.stb & ~ack_q;
	assign code_wr = bus_req & wb_req.we & (wb_req.adr == mdll_pkg::REG_CODE);
	// busy while any code is still in the datapath
	assign busy    = (state_q != mdll_pkg::ST_IDLE);

	// read mux, unmapped addresses give zero
	always_comb begin
		case (wb_req.adr)
			mdll_pkg::REG_CODE:   rd_data = mdll_pkg::wb_data_t'(code);
			mdll_pkg::REG_STATUS: rd_data = {31'b0, busy};
			mdll_pkg::REG_PHASE:  rd_data = mdll_pkg::wb_data_t'(phase_q);
			default:              rd_data = '0;
		endcase
	end

	// single cycle ack, read data in the ack cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q     <= 1'b0;
			rdat_q    <= '0;
			upd_valid <= 1'b0;
			code      <= '0;
		end else begin
			ack_q     <= bus_req;
			upd_valid <= code_wr;
			if (bus_req)
				rdat_q <= rd_data;
			// code register also feeds the decoder
			if (code_wr)
				code <= mdll_pkg::code_t'(wb_req.dat[$bits(mdll_pkg::code_t)-1:0]) & CODE_MASK;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdat_q;

	// ----------------------------------------------------------
	// update sequencing
	// ----------------------------------------------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			mdll_pkg::ST_IDLE:
				if (code_wr)
					state_d = mdll_pkg::ST_DECODE;
			// ack cycle blocks a new write here
			mdll_pkg::ST_DECODE:
				state_d = mdll_pkg::ST_BLEND;
			mdll_pkg::ST_BLEND: begin
				if (code_wr)
					state_d = mdll_pkg::ST_DECODE;
				// last code in flight retires
				else if (phase_valid && (inflight_q == 2'd1))
					state_d = mdll_pkg::ST_IDLE;
			end
			default:
				state_d = mdll_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q    <= mdll_pkg::ST_IDLE;
			inflight_q <= 2'd0;
			phase_q    <= '0;
		end else begin
			state_q <= state_d;
			// codes between bus write and phase capture
			case ({code_wr, phase_valid})
				2'b10:   inflight_q <= inflight_q + 2'd1;
				2'b01:   inflight_q <= inflight_q - 2'd1;
				default: inflight_q <= inflight_q;
			endcase
			if (phase_valid)
				phase_q <= phase_out;
		end
	end

endmodule

// ==== hw/mdll_dcdl_phase_blender.sv ====
// dcdl phase blender
`timescale 1ns/10ps

module mdll_dcdl_phase_blender #(
	parameter int N_PI = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               dec_valid,
	input  mdll_pkg::phase_t   phase_lead,
	input  mdll_pkg::phase_t   phase_lag,
	input  mdll_pkg::thm_t     ctl_thm,
	output logic               phase_valid,
	output mdll_pkg::phase_t   phase_out
);

	localparam int N_THM  = 2**N_PI - 1;
	localparam int PROD_W = $bits(mdll_pkg::phase_t) + N_PI;

	logic [N_PI-1:0]     weight;
	mdll_pkg::phase_t    diff;
	logic [PROD_W-1:0]   prod;
	mdll_pkg::phase_t    phase_d;

	// blend weight, ones in the thermometer word
	always_comb begin
		weight = '0;
		for (int i = 0; i < N_THM; i++) begin
			weight = weight + N_PI'(ctl_thm[i]);
		end
	end

	// lead to lag spacing, never negative
	assign diff = phase_lag - phase_lead;
	// weight over 2**N_PI, truncated
	assign prod = PROD_W'(diff) * PROD_W'(weight);
	assign phase_d = phase_lead + mdll_pkg::phase_t'(prod >> N_PI);

	// ----------------------------------------------------------
	// output phase register
	// ----------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_valid <= 1'b0;
			phase_out   <= '0;
		end else begin
			phase_valid <= dec_valid;
			if (dec_valid)
				phase_out <= phase_d;
		end
	end

endmodule

// ==== hw/mdll_dcdl_top.sv ====
// dcdl control and phase subsystem
`timescale 1ns/10ps

module mdll_dcdl_top #(
	parameter int N_PI        = 4,
	parameter int N_COARSE    = 3,
	parameter int STAGE_DELAY = 64
) (
	input  logic                clk,
	input  logic                rst_n,
	input  mdll_pkg::wb_req_t   wb_req,
	output mdll_pkg::wb_rsp_t   wb_rsp,
	output mdll_pkg::thm_t      ctl_thm,
	output mdll_pkg::phase_t    phase_out
);

	logic               upd_valid;
	mdll_pkg::code_t    code;
	logic               dec_valid;
	mdll_pkg::code_t    coarse_sel;
	mdll_pkg::phase_t   phase_lead;
	mdll_pkg::phase_t   phase_lag;
	logic               phase_valid;

	// ----------------------------------------------------------
	// control
	// ----------------------------------------------------------

	// host registers and update tracking
	mdll_dcdl_ctrl #(
		.N_PI     (N_PI),
		.N_COARSE (N_COARSE)
	) u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.upd_valid   (upd_valid),
		.code        (code),
		.phase_valid (phase_valid),
		.phase_out   (phase_out)
	);

	// ----------------------------------------------------------
	// datapath
	// ----------------------------------------------------------

	// code split, one cycle
	mdll_dcdl_code_decoder #(
		.N_PI     (N_PI),
		.N_COARSE (N_COARSE)
	) u_decoder (
		.clk        (clk),
		.rst_n      (rst_n),
		.upd_valid  (upd_valid),
		.code       (code),
		.dec_valid  (dec_valid),
		.coarse_sel (coarse_sel),
		.ctl_thm    (ctl_thm)
	);

	// tap phases, combinational
	mdll_dcdl_coarse_chain #(
		.STAGE_DELAY (STAGE_DELAY)
	) u_chain (
		.coarse_sel (coarse_sel),
		.phase_lead (phase_lead),
		.phase_lag  (phase_lag)
	);

	// interpolation, one cycle
	mdll_dcdl_phase_blender #(
		.N_PI (N_PI)
	) u_blender (
		.clk         (clk),
		.rst_n       (rst_n),
		.dec_valid   (dec_valid),
		.phase_lead  (phase_lead),
		.phase_lag   (phase_lag),
		.ctl_thm     (ctl_thm),
		.phase_valid (phase_valid),
		.phase_out   (phase_out)
	);

endmodule

// ==== hw/mdll_pkg.sv ====
// mdll dcdl shared types
package mdll_pkg;

	// ----------------------------------------------------------
	// datapath widths
	// ----------------------------------------------------------

	// phase in delay units of the quantized model
	typedef logic [15:0] phase_t;
	// delay code, low N_COARSE+N_PI bits meaningful
	typedef logic [7:0] code_t;
	// thermometer word, low 2**N_PI-1 bits used
	typedef logic [15:0] thm_t;

	// ----------------------------------------------------------
	// wishbone classic bus
	// ----------------------------------------------------------

	typedef logic [31:0] wb_data_t;
	// word address
	typedef logic [3:0] wb_addr_t;

	// master to slave request
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_addr_t adr;
		wb_data_t dat;
	} wb_req_t;

	// slave to master response
	typedef struct packed {
		logic     ack;
		wb_data_t dat;
	} wb_rsp_t;

	// register map
	localparam wb_addr_t REG_CODE   = 4'd0;
	// busy in bit 0
	localparam wb_addr_t REG_STATUS = 4'd1;
	localparam wb_addr_t REG_PHASE  = 4'd2;

	// update sequencing states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DECODE,
		ST_BLEND
	} upd_state_t;

endpackage

// ==== list.f ====
hw/mdll_pkg.sv
hw/mdll_dcdl_ctrl.sv
hw/mdll_dcdl_code_decoder.sv
hw/mdll_dcdl_coarse_chain.sv
hw/mdll_dcdl_phase_blender.sv
hw/mdll_dcdl_top.sv
dv/mdll_dcdl_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dcdl testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f list.f \
	--top-module mdll_dcdl_tb

./obj_dir/Vmdll_dcdl_tb > sim.log 2>&1
cat sim.log

if grep -qx "Testbench passed" sim.log; then
	exit 0
else
	exit 1
fi
